/* flist.f */
common/eth_mac_pkg.sv
logic/eth_frame_fifo.sv
eth_mac/eth_mac_tx.sv
eth_mac/eth_mac_rx.sv
logic/eth_mac_fifo.sv
verification/eth_mac_fifo_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the MAC loopback testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f \
    --top-module eth_mac_fifo_tb -o sim_eth_mac_fifo > build.log 2>&1 \
    || { echo "Verilator build failed, see build.log"; exit 1; }

./obj_dir/sim_eth_mac_fifo > sim.log 2>&1

grep -q "^RESULT: PASS$" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }

/* verification/eth_mac_fifo_tb.sv */
//******************************
// Loopback testbench for the
// Ethernet MAC with frame FIFOs
//******************************
module eth_mac_fifo_tb
    import eth_mac_pkg::*;
();

    localparam int num_frames     = 40;
    localparam int max_len        = 100;
    localparam int clk_period     = 20;
    localparam int timeout_cycles = num_frames * 400 + 2000;
    localparam logic [7:0] corrupt_value = 8'hA5;

    logic       logic_clk;
    logic       logic_rst;
    logic [7:0] tx_axis_tdata;
    logic       tx_axis_tvalid;
    logic       tx_axis_tready;
    logic       tx_axis_tlast;
    logic       tx_axis_tuser;
    logic [7:0] rx_axis_tdata;
    logic       rx_axis_tvalid;
    logic       rx_axis_tready;
    logic       rx_axis_tlast;
    logic [7:0] gmii_rxd;
    logic       gmii_rx_dv;
    logic       gmii_rx_er;
    logic [7:0] gmii_txd;
    logic       gmii_tx_en;
    logic       gmii_tx_er;
    logic [7:0] ifg_delay;
    logic       tx_fifo_overflow;
    logic       tx_fifo_bad_frame;
    logic       tx_fifo_good_frame;
    logic       rx_error_bad_frame;
    logic       rx_error_bad_fcs;
    logic       rx_fifo_overflow;
    logic       rx_fifo_bad_frame;
    logic       rx_fifo_good_frame;

    // Stimulus, built once before reset
    int         seed;
    int         frame_len [num_frames];
    bit         frame_bad [num_frames];
    bit         frame_corrupt [num_frames];
    int         frame_cpos [num_frames];
    int         frame_idle [num_frames];
    logic [7:0] frame_data [num_frames][max_len];

    // Frames that reach GMII, in order
    int gmii_len [num_frames];
    bit gmii_corrupt [num_frames];
    int gmii_cpos [num_frames];
    int gmii_total;
    int good_total;
    int bad_total;
    int corrupt_total;

    // Reference model of the rx_axis byte stream
    logic [7:0] exp_data [$];
    bit         exp_last [$];

    int         tx_byte_idx;
    int         gmii_frame_idx;
    int         gap_cnt;
    bit         tx_en_prev;
    bit         seen_frame;
    int         cycle_cnt;
    int         rx_frame_cnt;
    int         rx_byte_cnt;
    logic [7:0] corrupt_mask;

    int cnt_tx_overflow;
    int cnt_tx_bad;
    int cnt_tx_good;
    int cnt_rx_bad_frame;
    int cnt_rx_bad_fcs;
    int cnt_rx_overflow;
    int cnt_rx_fifo_bad;
    int cnt_rx_fifo_good;

    eth_mac_fifo i_eth_mac_fifo (.*);

    // Loopback, with one payload byte flipped in marked frames
    assign corrupt_mask = (gmii_tx_en && gmii_frame_idx < num_frames
        && gmii_corrupt[gmii_frame_idx]
        && tx_byte_idx == gmii_cpos[gmii_frame_idx] + preamble_bytes + 1)
        ? corrupt_value : 8'h00;
    assign gmii_rxd   = gmii_txd ^ corrupt_mask;
    assign gmii_rx_dv = gmii_tx_en;
    assign gmii_rx_er = gmii_tx_er;

    initial begin
        logic_clk = 1'b0;
        forever #(clk_period / 2) logic_clk = ~logic_clk;
    end

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("RESULT: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compare_byte(input string name, input logic [7:0] exp_d,
                                input logic [7:0] act_d, input logic exp_l,
                                input logic act_l);
        if (act_d !== exp_d) begin
            stop_on_failure($sformatf("ERROR %s data: expected %02h, actual %02h",
                                      name, exp_d, act_d));
        end
        if (act_l !== exp_l) begin
            stop_on_failure($sformatf("ERROR %s tlast: expected %0b, actual %0b",
                                      name, exp_l, act_l));
        end
    endtask

    task automatic compare_count(input string name, input int exp_v, input int act_v);
        if (act_v != exp_v) begin
            stop_on_failure($sformatf("ERROR %s: expected %0d, actual %0d",
                                      name, exp_v, act_v));
        end
    endtask

    task automatic generate_frames();
        int i;
        int j;
        int n;
        for (i = 0; i < num_frames; i++) begin
            frame_len[i] = ((seed_next() & 32'h7FFF_FFFF) % max_len) + 1;
            // Frame 1 is always short, to exercise padding
            if (i == 1) begin
                frame_len[i] = ((seed_next() & 32'h7FFF_FFFF) % (min_payload - 1)) + 1;
            end
            for (j = 0; j < max_len; j++) begin
                frame_data[i][j] = 8'(seed_next());
            end
            frame_bad[i]     = (i == 2) || ((seed_next() & 7) == 0);
            frame_corrupt[i] = !frame_bad[i] && ((i == 3) || ((seed_next() & 7) == 0));
            frame_cpos[i]    = (seed_next() & 32'h7FFF_FFFF) % frame_len[i];
            frame_idle[i]    = seed_next() & 3;

            if (frame_bad[i]) begin
                bad_total++;
            end else begin
                n = (frame_len[i] < min_payload) ? min_payload : frame_len[i];
                gmii_len[gmii_total]     = n;
                gmii_corrupt[gmii_total] = frame_corrupt[i];
                gmii_cpos[gmii_total]    = frame_cpos[i];
                gmii_total++;
                if (frame_corrupt[i]) begin
                    corrupt_total++;
                end else begin
                    good_total++;
                    // Payload, then zero fill up to the minimum
                    for (j = 0; j < n; j++) begin
                        exp_data.push_back((j < frame_len[i]) ? frame_data[i][j] : 8'h00);
                        exp_last.push_back(j == n - 1);
                    end
                end
            end
        end
    endtask

    function automatic int seed_next();
        return $random(seed);
    endfunction

    task automatic send_frame(input int f);
        int  j;
        bit  accepted;
        for (j = 0; j < frame_len[f]; j++) begin
            tx_axis_tvalid = 1'b1;
            tx_axis_tdata  = frame_data[f][j];
            tx_axis_tlast  = (j == frame_len[f] - 1);
            tx_axis_tuser  = frame_bad[f] && (j == frame_len[f] - 1);
            accepted = 1'b0;
            // Ready only changes on a clock edge
            while (!accepted) begin
                accepted = tx_axis_tready;
                @(posedge logic_clk);
                #2;
            end
        end
        tx_axis_tvalid = 1'b0;
        tx_axis_tlast  = 1'b0;
        tx_axis_tuser  = 1'b0;
        repeat (frame_idle[f]) begin
            @(posedge logic_clk);
            #2;
        end
    endtask

    initial begin
        bit done;
        int f;
        seed           = 32'h5258_5578;
        logic_rst      = 1'b1;
        tx_axis_tdata  = 8'h00;
        tx_axis_tvalid = 1'b0;
        tx_axis_tlast  = 1'b0;
        tx_axis_tuser  = 1'b0;
        rx_axis_tready = 1'b0;
        ifg_delay      = 8'(ifg_min);
        generate_frames();

        repeat (5) @(posedge logic_clk);
        #2;
        logic_rst = 1'b0;

        for (f = 0; f < num_frames; f++) begin
            send_frame(f);
        end

        // All GMII frames done, all status seen, model drained
        done = 1'b0;
        while (!done) begin
            @(posedge logic_clk);
            #2;
            done = (exp_data.size() == 0) && (gmii_frame_idx == gmii_total)
                && (cnt_rx_fifo_good + cnt_rx_fifo_bad == gmii_total);
        end

        compare_count("tx_fifo_good_frame count", gmii_total, cnt_tx_good);
        compare_count("tx_fifo_bad_frame count", bad_total, cnt_tx_bad);
        compare_count("tx_fifo_overflow count", 0, cnt_tx_overflow);
        compare_count("rx_error_bad_frame count", corrupt_total, cnt_rx_bad_frame);
        compare_count("rx_error_bad_fcs count", corrupt_total, cnt_rx_bad_fcs);
        compare_count("rx_fifo_bad_frame count", corrupt_total, cnt_rx_fifo_bad);
        compare_count("rx_fifo_good_frame count", good_total, cnt_rx_fifo_good);
        compare_count("rx_fifo_overflow count", 0, cnt_rx_overflow);

        $display("RESULT: PASS");
        $finish;
    end

    // Random stalls on the receive stream, about one cycle in four
    initial begin
        wait (logic_rst === 1'b0);
        forever begin
            @(posedge logic_clk);
            #2;
            rx_axis_tready = ((seed_next() & 3) != 0);
        end
    end

    // Output checker
    always @(posedge logic_clk) begin
        if (!logic_rst && rx_axis_tvalid && rx_axis_tready) begin
            if (exp_data.size() == 0) begin
                stop_on_failure("rx_axis delivered a byte while no frame was expected");
            end else begin
                compare_byte($sformatf("rx frame %0d byte %0d", rx_frame_cnt, rx_byte_cnt),
                             exp_data[0], rx_axis_tdata, exp_last[0], rx_axis_tlast);
                void'(exp_data.pop_front());
                void'(exp_last.pop_front());
                rx_byte_cnt++;
                if (rx_axis_tlast) begin
                    rx_frame_cnt++;
                    rx_byte_cnt = 0;
                end
            end
        end
    end

    // GMII monitor: frame length on tx_en and the gap before each frame
    always @(posedge logic_clk) begin
        if (logic_rst) begin
            tx_byte_idx    <= 0;
            gmii_frame_idx <= 0;
            gap_cnt        <= 0;
            tx_en_prev     <= 1'b0;
            seen_frame     <= 1'b0;
        end else begin
            if (gmii_tx_er !== 1'b0) begin
                stop_on_failure("gmii_tx_er was asserted by the transmitter");
            end
            if (gmii_tx_en) begin
                if (!tx_en_prev && seen_frame && gap_cnt < ifg_min) begin
                    stop_on_failure($sformatf("inter-frame gap of %0d cycles is below %0d",
                                              gap_cnt, ifg_min));
                end
                tx_byte_idx <= tx_byte_idx + 1;
                gap_cnt     <= 0;
            end else begin
                if (tx_en_prev) begin
                    if (gmii_frame_idx >= gmii_total) begin
                        stop_on_failure("GMII sent more frames than good frames were queued");
                    end else begin
                        compare_count($sformatf("gmii frame %0d tx_en length", gmii_frame_idx),
                                      gmii_len[gmii_frame_idx] + preamble_bytes + 1 + 4,
                                      tx_byte_idx);
                    end
                    gmii_frame_idx <= gmii_frame_idx + 1;
                    seen_frame     <= 1'b1;
                end
                tx_byte_idx <= 0;
                gap_cnt     <= gap_cnt + 1;
            end
            tx_en_prev <= gmii_tx_en;
        end
    end

    // Status pulse counters
    always @(posedge logic_clk) begin
        if (!logic_rst) begin
            cnt_tx_overflow  <= cnt_tx_overflow + int'(tx_fifo_overflow);
            cnt_tx_bad       <= cnt_tx_bad + int'(tx_fifo_bad_frame);
            cnt_tx_good      <= cnt_tx_good + int'(tx_fifo_good_frame);
            cnt_rx_bad_frame <= cnt_rx_bad_frame + int'(rx_error_bad_frame);
            cnt_rx_bad_fcs   <= cnt_rx_bad_fcs + int'(rx_error_bad_fcs);
            cnt_rx_overflow  <= cnt_rx_overflow + int'(rx_fifo_overflow);
            cnt_rx_fifo_bad  <= cnt_rx_fifo_bad + int'(rx_fifo_bad_frame);
            cnt_rx_fifo_good <= cnt_rx_fifo_good + int'(rx_fifo_good_frame);
        end
    end

    always @(posedge logic_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= timeout_cycles) begin
            stop_on_failure("timeout: received frames missing");
        end
    end

endmodule

/* logic/eth_mac_fifo.sv */
//******************************
// Gigabit Ethernet MAC with
// transmit and receive frame FIFOs
//******************************
module eth_mac_fifo
    import eth_mac_pkg::*;
(
    input  logic       logic_clk,
    input  logic       logic_rst,

    // Transmit stream
    input  logic [7:0] tx_axis_tdata,
    input  logic       tx_axis_tvalid,
    output logic       tx_axis_tready,
    input  logic       tx_axis_tlast,
    input  logic       tx_axis_tuser,

    // Receive stream
    output logic [7:0] rx_axis_tdata,
    output logic       rx_axis_tvalid,
    input  logic       rx_axis_tready,
    output logic       rx_axis_tlast,

    // GMII
    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,
    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er,

    input  logic [7:0] ifg_delay,

    // Status pulses
    output logic       tx_fifo_overflow,
    output logic       tx_fifo_bad_frame,
    output logic       tx_fifo_good_frame,
    output logic       rx_error_bad_frame,
    output logic       rx_error_bad_fcs,
    output logic       rx_fifo_overflow,
    output logic       rx_fifo_bad_frame,
    output logic       rx_fifo_good_frame
);

    logic [7:0] tx_fifo_tdata;
    logic       tx_fifo_tvalid;
    logic       tx_fifo_tready;
    logic       tx_fifo_tlast;

    logic [7:0] rx_mac_tdata;
    logic       rx_mac_tvalid;
    logic       rx_mac_tlast;
    logic       rx_mac_tuser;

    // Back-pressure toward the source
    eth_frame_fifo #(
        .addr_width     (fifo_addr_width),
        .drop_when_full (1'b0)
    ) tx_fifo (
        .logic_clk         (logic_clk),
        .logic_rst         (logic_rst),
        .in_tdata          (tx_axis_tdata),
        .in_tvalid         (tx_axis_tvalid),
        .in_tready         (tx_axis_tready),
        .in_tlast          (tx_axis_tlast),
        .in_tuser          (tx_axis_tuser),
        .out_tdata         (tx_fifo_tdata),
        .out_tvalid        (tx_fifo_tvalid),
        .out_tready        (tx_fifo_tready),
        .out_tlast         (tx_fifo_tlast),
        .status_overflow   (tx_fifo_overflow),
        .status_bad_frame  (tx_fifo_bad_frame),
        .status_good_frame (tx_fifo_good_frame)
    );

    eth_mac_tx i_eth_mac_tx (
        .logic_clk  (logic_clk),
        .logic_rst  (logic_rst),
        .tx_tdata   (tx_fifo_tdata),
        .tx_tvalid  (tx_fifo_tvalid),
        .tx_tready  (tx_fifo_tready),
        .tx_tlast   (tx_fifo_tlast),
        .ifg_delay  (ifg_delay),
        .gmii_txd   (gmii_txd),
        .gmii_tx_en (gmii_tx_en),
        .gmii_tx_er (gmii_tx_er)
    );

    eth_mac_rx i_eth_mac_rx (
        .logic_clk       (logic_clk),
        .logic_rst       (logic_rst),
        .gmii_rxd        (gmii_rxd),
        .gmii_rx_dv      (gmii_rx_dv),
        .gmii_rx_er      (gmii_rx_er),
        .rx_tdata        (rx_mac_tdata),
        .rx_tvalid       (rx_mac_tvalid),
        .rx_tlast        (rx_mac_tlast),
        .rx_tuser        (rx_mac_tuser),
        .error_bad_frame (rx_error_bad_frame),
        .error_bad_fcs   (rx_error_bad_fcs)
    );

    // Receiver cannot stall, so frames that do not fit are dropped
    eth_frame_fifo #(
        .addr_width     (fifo_addr_width),
        .drop_when_full (1'b1)
    ) rx_fifo (
        .logic_clk         (logic_clk),
        .logic_rst         (logic_rst),
        .in_tdata          (rx_mac_tdata),
        .in_tvalid         (rx_mac_tvalid),
        .in_tready         (),
        .in_tlast          (rx_mac_tlast),
        .in_tuser          (rx_mac_tuser),
        .out_tdata         (rx_axis_tdata),
        .out_tvalid        (rx_axis_tvalid),
        .out_tready        (rx_axis_tready),
        .out_tlast         (rx_axis_tlast),
        .status_overflow   (rx_fifo_overflow),
        .status_bad_frame  (rx_fifo_bad_frame),
        .status_good_frame (rx_fifo_good_frame)
    );

endmodule

/* eth_mac/eth_mac_rx.sv */
//******************************
// GMII receiver
// Strips preamble, checks and
// removes the FCS
//******************************
module eth_mac_rx
    import eth_mac_pkg::*;
(
    input  logic       logic_clk,
    input  logic       logic_rst,

    input  logic [7:0] gmii_rxd,
    input  logic       gmii_rx_dv,
    input  logic       gmii_rx_er,

    output logic [7:0] rx_tdata,
    output logic       rx_tvalid,
    output logic       rx_tlast,
    output logic       rx_tuser,

    output logic       error_bad_frame,
    output logic       error_bad_fcs
);

    logic        in_frame;
    // Holds the last four bytes, which become the FCS at frame end
    logic [7:0]  dly [4];
    logic [2:0]  fill;
    // Bytes after the SFD, saturating at the minimum frame
    logic [6:0]  len;
    logic        er_seen;
    logic [31:0] crc;
    logic        fcs_bad;
    logic        frame_bad;

    assign fcs_bad   = (crc != crc32_residue);
    assign frame_bad = fcs_bad || er_seen || (len < 7'(min_frame_length));

    // Data-valid dropping marks the byte now on the output as the last one
    assign rx_tlast = rx_tvalid && !gmii_rx_dv;
    assign rx_tuser = rx_tlast && frame_bad;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            in_frame        <= 1'b0;
            fill            <= '0;
            len             <= '0;
            er_seen         <= 1'b0;
            crc             <= crc32_init;
            rx_tvalid       <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;
        end else begin
            rx_tvalid       <= 1'b0;
            error_bad_frame <= 1'b0;
            error_bad_fcs   <= 1'b0;

            if (!in_frame) begin
                // Skip preamble until the SFD
                if (gmii_rx_dv && gmii_rxd == eth_sfd) begin
                    in_frame <= 1'b1;
                    fill     <= '0;
                    len      <= '0;
                    er_seen  <= gmii_rx_er;
                    crc      <= crc32_init;
                end
            end else if (gmii_rx_dv) begin
                crc <= crc32_step(crc, gmii_rxd);
                if (fill < 3'd4) begin
                    fill <= fill + 3'd1;
                end else begin
                    rx_tvalid <= 1'b1;
                end
                if (len < 7'(min_frame_length)) begin
                    len <= len + 7'd1;
                end
                if (gmii_rx_er) begin
                    er_seen <= 1'b1;
                end
            end else begin
                in_frame        <= 1'b0;
                error_bad_frame <= frame_bad;
                error_bad_fcs   <= fcs_bad;
            end
        end
    end

    // Delay line and output byte
    always_ff @(posedge logic_clk) begin
        if (in_frame && gmii_rx_dv) begin
            dly[0]   <= gmii_rxd;
            dly[1]   <= dly[0];
            dly[2]   <= dly[1];
            dly[3]   <= dly[2];
            rx_tdata <= dly[3];
        end
    end

    // Every output byte is pushed out by a received byte of the same frame
    a_valid_in_frame: assert property (@(posedge logic_clk) disable iff (logic_rst)
        rx_tvalid |-> (in_frame && $past(gmii_rx_dv)));

endmodule

/* eth_mac/eth_mac_tx.sv */
//******************************
// GMII transmitter
// Preamble, padding, FCS and
// inter-frame gap
//******************************
module eth_mac_tx
    import eth_mac_pkg::*;
(
    input  logic       logic_clk,
    input  logic       logic_rst,

    input  logic [7:0] tx_tdata,
    input  logic       tx_tvalid,
    output logic       tx_tready,
    input  logic       tx_tlast,

    input  logic [7:0] ifg_delay,

    output logic [7:0] gmii_txd,
    output logic       gmii_tx_en,
    output logic       gmii_tx_er
);

    typedef enum logic [2:0] {
        st_idle,
        st_preamble,
        st_payload,
        st_pad,
        st_fcs,
        st_gap
    } tx_state_t;

    tx_state_t   state;
    // Byte count within the current phase
    logic [7:0]  cnt;
    logic [31:0] crc;
    logic [7:0]  ifg_eff;

    assign ifg_eff = (ifg_delay < 8'(ifg_min)) ? 8'(ifg_min) : ifg_delay;

    // FIFO bytes are taken only while payload goes out
    assign tx_tready = (state == st_payload);

    // Frames come complete out of the FIFO, nothing to signal
    assign gmii_tx_er = 1'b0;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            state      <= st_idle;
            cnt        <= '0;
            crc        <= crc32_init;
            gmii_txd   <= '0;
            gmii_tx_en <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    gmii_tx_en <= 1'b0;
                    gmii_txd   <= 8'h00;
                    if (tx_tvalid) begin
                        gmii_tx_en <= 1'b1;
                        gmii_txd   <= eth_preamble;
                        cnt        <= 8'd1;
                        state      <= st_preamble;
                    end
                end
                st_preamble: begin
                    if (cnt < 8'(preamble_bytes)) begin
                        gmii_txd <= eth_preamble;
                        cnt      <= cnt + 8'd1;
                    end else begin
                        gmii_txd <= eth_sfd;
                        crc      <= crc32_init;
                        cnt      <= '0;
                        state    <= st_payload;
                    end
                end
                st_payload: begin
                    if (tx_tvalid) begin
                        gmii_txd <= tx_tdata;
                        crc      <= crc32_step(crc, tx_tdata);
                        if (cnt < 8'(min_payload)) begin
                            cnt <= cnt + 8'd1;
                        end
                        if (tx_tlast) begin
                            if (cnt >= 8'(min_payload - 1)) begin
                                cnt   <= '0;
                                state <= st_fcs;
                            end else begin
                                state <= st_pad;
                            end
                        end
                    end
                end
                st_pad: begin
                    // Zero fill up to the minimum payload
                    gmii_txd <= 8'h00;
                    crc      <= crc32_step(crc, 8'h00);
                    cnt      <= cnt + 8'd1;
                    if (cnt == 8'(min_payload - 1)) begin
                        cnt   <= '0;
                        state <= st_fcs;
                    end
                end
                st_fcs: begin
                    // Inverted CRC, low byte first
                    gmii_txd <= ~crc[7:0];
                    crc      <= {8'h00, crc[31:8]};
                    cnt      <= cnt + 8'd1;
                    if (cnt == 8'd3) begin
                        cnt   <= '0;
                        state <= st_gap;
                    end
                end
                st_gap: begin
                    gmii_tx_en <= 1'b0;
                    gmii_txd   <= 8'h00;
                    cnt        <= cnt + 8'd1;
                    if (cnt + 8'd1 >= ifg_eff) begin
                        state <= st_idle;
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    // Whole frames sit in the FIFO, so payload bytes never run out
    a_no_underflow: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (state == st_payload) |-> tx_tvalid);

endmodule

/* logic/eth_frame_fifo.sv */
//******************************
// Store-and-forward frame FIFO
// Drops bad frames, optionally drops
// frames that do not fit
//******************************
module eth_frame_fifo
    import eth_mac_pkg::*;
#(
    parameter int addr_width     = fifo_addr_width,
    parameter bit drop_when_full = 1'b0
) (
    input  logic       logic_clk,
    input  logic       logic_rst,

    input  logic [7:0] in_tdata,
    input  logic       in_tvalid,
    output logic       in_tready,
    input  logic       in_tlast,
    input  logic       in_tuser,

    output logic [7:0] out_tdata,
    output logic       out_tvalid,
    input  logic       out_tready,
    output logic       out_tlast,

    output logic       status_overflow,
    output logic       status_bad_frame,
    output logic       status_good_frame
);

    logic [fifo_entry_width-1:0] mem [2**addr_width];

    // Committed, speculative and read pointers, one extra wrap bit
    logic [addr_width:0] wr_ptr;
    logic [addr_width:0] wr_ptr_cur;
    logic [addr_width:0] rd_ptr;
    logic [addr_width:0] used_cur;
    logic [addr_width:0] used_com;

    logic                        full_cur;
    logic                        empty;
    logic                        drop_frame;
    logic                        in_xfer;
    logic                        mem_we;
    logic                        mem_rd_en;
    logic                        mem_rd_valid;
    logic [fifo_entry_width-1:0] mem_rd_data;
    logic                        store_output;

    assign used_cur = wr_ptr_cur - rd_ptr;
    assign used_com = wr_ptr - rd_ptr;
    assign full_cur = used_cur[addr_width];
    assign empty    = (used_com == '0);

    assign in_xfer = in_tvalid && in_tready;
    assign mem_we  = in_xfer && !drop_frame && !full_cur;

    // Two output stages, RAM read then output register
    assign store_output = out_tready || !out_tvalid;
    assign mem_rd_en    = !empty && (!mem_rd_valid || store_output);

    // Write side
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            in_tready         <= 1'b0;
            wr_ptr            <= '0;
            wr_ptr_cur        <= '0;
            drop_frame        <= 1'b0;
            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;
        end else begin
            // One spare slot covers the write in flight
            in_tready <= drop_when_full || (used_cur < {1'b0, {addr_width{1'b1}}});

            status_overflow   <= 1'b0;
            status_bad_frame  <= 1'b0;
            status_good_frame <= 1'b0;

            if (in_xfer) begin
                if (!mem_we) begin
                    // Frame did not fit, discard until its tlast
                    wr_ptr_cur      <= wr_ptr;
                    drop_frame      <= !in_tlast;
                    status_overflow <= in_tlast;
                end else if (in_tlast && in_tuser) begin
                    wr_ptr_cur       <= wr_ptr;
                    status_bad_frame <= 1'b1;
                end else if (in_tlast) begin
                    wr_ptr_cur        <= wr_ptr_cur + 1'b1;
                    wr_ptr            <= wr_ptr_cur + 1'b1;
                    status_good_frame <= 1'b1;
                end else begin
                    wr_ptr_cur <= wr_ptr_cur + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (mem_we) begin
            mem[wr_ptr_cur[addr_width-1:0]] <= {in_tlast, in_tdata};
        end
    end

    // Read side
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr       <= '0;
            mem_rd_valid <= 1'b0;
            out_tvalid   <= 1'b0;
        end else begin
            if (store_output) begin
                out_tvalid <= mem_rd_valid;
            end
            if (mem_rd_en) begin
                rd_ptr       <= rd_ptr + 1'b1;
                mem_rd_valid <= 1'b1;
            end else if (store_output) begin
                mem_rd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (mem_rd_en) begin
            mem_rd_data <= mem[rd_ptr[addr_width-1:0]];
        end
        if (store_output) begin
            {out_tlast, out_tdata} <= mem_rd_data;
        end
    end

    // Registered ready must fall before the RAM fills
    a_no_write_full: assert property (@(posedge logic_clk) disable iff (logic_rst)
        (!drop_when_full && in_xfer) |-> !full_cur);

    // Reader never passes the committed write pointer
    a_no_read_empty: assert property (@(posedge logic_clk) disable iff (logic_rst)
        used_com <= used_cur);

endmodule

/* common/eth_mac_pkg.sv */
//******************************
// Ethernet MAC shared package
// Frame constants, FIFO geometry and
// the CRC-32 byte update
//******************************
package eth_mac_pkg;

    // FIFO depth is 2**fifo_addr_width bytes
    localparam int fifo_addr_width = 11;
    // Data byte plus tlast
    localparam int fifo_entry_width = 9;

    // Minimum frame, FCS included
    localparam int min_frame_length = 64;
    localparam int min_payload = min_frame_length - 4;

    // Preamble length and smallest legal gap
    localparam int preamble_bytes = 7;
    localparam int ifg_min = 12;

    localparam logic [7:0] eth_preamble = 8'h55;
    localparam logic [7:0] eth_sfd = 8'hD5;

    // Reflected 802.3 polynomial
    localparam logic [31:0] crc32_poly = 32'hEDB8_8320;
    localparam logic [31:0] crc32_init = 32'hFFFF_FFFF;
    // Register contents after data plus a correct FCS
    localparam logic [31:0] crc32_residue = 32'hDEBB_20E3;

    // One byte through the CRC register, LSB first
    function automatic logic [31:0] crc32_step(
        input logic [31:0] crc,
        input logic [7:0]  data
    );
        logic [31:0] c;
        int i;
        c = crc ^ {24'd0, data};
        for (i = 0; i < 8; i++) begin
            if (c[0]) begin
                c = (c >> 1) ^ crc32_poly;
            end else begin
                c = c >> 1;
            end
        end
        return c;
    endfunction

endpackage
